/* Bender.yml */
package:
  name: maze_display

sources:
  - hdl/game_pkg.sv
  - hdl/video_pkg.sv
  - hdl/frame_sequencer.sv
  - hdl/tile_renderer.sv
  - hdl/player_unit.sv
  - hdl/frame_buffer.sv
  - hdl/pixel_streamer.sv
  - hdl/maze_display.sv
  - target: test
    files:
      - tests/maze_display_chk.sv
      - tests/maze_display_checker.sv
      - tests/maze_display_tb.sv

/* hdl/frame_buffer.sv */
module frame_buffer (
    input  logic                          clock,
    input  game_pkg::stage_t              stage,
    input  logic                          tile_wr_en,
    input  logic [video_pkg::FB_AW-1:0]   tile_wr_addr,
    input  video_pkg::color_t             tile_wr_color,
    input  logic                          player_wr_en,
    input  logic [video_pkg::FB_AW-1:0]   player_wr_addr,
    input  video_pkg::color_t             player_wr_color,
    input  logic [video_pkg::FB_AW-1:0]   rd_addr,
    output video_pkg::color_t             rd_color
);

    video_pkg::color_t              mem [video_pkg::CANVAS_W * video_pkg::CANVAS_H];
    logic                           wr_en;
    logic [video_pkg::FB_AW-1:0]    wr_addr;
    video_pkg::color_t              wr_color;

    // Writer picked by the running stage
    always_comb begin
        wr_en    = (stage == game_pkg::TILES) ? tile_wr_en : 1'b0;
        wr_addr  = tile_wr_addr;
        wr_color = tile_wr_color;
        if (stage == game_pkg::PLAYER) begin
            wr_en    = player_wr_en;
            wr_addr  = player_wr_addr;
            wr_color = player_wr_color;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en)
            mem[wr_addr] <= wr_color;
        rd_color <= mem[rd_addr];   // Registered read
    end

endmodule

/* hdl/frame_sequencer.sv */
module frame_sequencer (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          frame_start,
    input  logic                          move_done,
    input  logic                          tiles_done,
    input  logic                          player_done,
    input  logic                          scan_done,
    input  logic [game_pkg::MAP_AW-1:0]   move_map_addr,
    input  logic [game_pkg::MAP_AW-1:0]   tile_map_addr,
    output game_pkg::stage_t              stage,
    output logic                          move_go,
    output logic                          tiles_go,
    output logic                          player_go,
    output logic                          scan_go,
    output logic                          frame_busy,
    output logic [game_pkg::MAP_AW-1:0]   map_addr
);

    // Go pulses line up with the first cycle of their stage
    always_ff @(posedge clock) begin
        if (!resetn) begin
            stage     <= game_pkg::IDLE;
            move_go   <= 1'b0;
            tiles_go  <= 1'b0;
            player_go <= 1'b0;
            scan_go   <= 1'b0;
        end else begin
            move_go   <= 1'b0;  // Single cycle pulses
            tiles_go  <= 1'b0;
            player_go <= 1'b0;
            scan_go   <= 1'b0;
            case (stage)
                game_pkg::IDLE: if (frame_start) begin
                    stage   <= game_pkg::MOVE;
                    move_go <= 1'b1;
                end
                game_pkg::MOVE: if (move_done) begin
                    stage    <= game_pkg::TILES;
                    tiles_go <= 1'b1;
                end
                game_pkg::TILES: if (tiles_done) begin
                    stage     <= game_pkg::PLAYER;
                    player_go <= 1'b1;
                end
                game_pkg::PLAYER: if (player_done) begin
                    stage   <= game_pkg::SCAN;
                    scan_go <= 1'b1;
                end
                game_pkg::SCAN: if (scan_done) stage <= game_pkg::IDLE;  // Ends on last pixel
                default: stage <= game_pkg::IDLE;
            endcase
        end
    end

    assign frame_busy = (stage != game_pkg::IDLE);  // Starts ignored while high

    // Map port belongs to the tile pass, otherwise to the move check
    assign map_addr = (stage == game_pkg::TILES) ? tile_map_addr : move_map_addr;

endmodule

/* hdl/game_pkg.sv */
package game_pkg;

    // Maze grid, counted in tiles
    localparam int GRID_W  = 29;
    localparam int GRID_H  = 13;
    localparam int TILE_PX = 5;     // Tile edge in canvas pixels

    localparam int MAP_AW  = 9;     // Map address is row * GRID_W + column
    localparam int TILE_XW = 5;
    localparam int TILE_YW = 4;

    // Tile the player returns to on reset
    localparam int PLAYER_START_X = 1;
    localparam int PLAYER_START_Y = 1;

    // Requested move, sampled at the start of a frame
    typedef enum logic [2:0] {
        NONE  = 3'd0,
        UP    = 3'd1,
        LEFT  = 3'd2,
        DOWN  = 3'd3,
        RIGHT = 3'd4
    } direction_t;

    // Frame stages in running order
    typedef enum logic [2:0] {
        IDLE, MOVE, TILES, PLAYER, SCAN
    } stage_t;

endpackage

/* hdl/maze_display.sv */
module maze_display #(
    parameter int PIXEL_CREDITS = 4
) (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          frame_start,
    input  game_pkg::direction_t          direction,
    input  logic                          map_wall,
    input  logic                          map_food,
    input  logic                          pixel_credit,
    output logic                          frame_busy,
    output logic [game_pkg::MAP_AW-1:0]   map_addr,
    output logic [game_pkg::TILE_XW-1:0]  player_x,
    output logic [game_pkg::TILE_YW-1:0]  player_y,
    output logic                          pixel_valid,
    output video_pkg::color_t             pixel_color
);

    game_pkg::stage_t               stage;
    logic                           move_go, tiles_go, player_go, scan_go;
    logic                           move_done, tiles_done, player_done, scan_done;
    logic [game_pkg::MAP_AW-1:0]    move_map_addr, tile_map_addr;
    logic                           tile_wr_en, player_wr_en;
    logic [video_pkg::FB_AW-1:0]    tile_wr_addr, player_wr_addr, rd_addr;
    video_pkg::color_t              tile_wr_color, player_wr_color, rd_color;

    frame_sequencer frame_sequencer_inst (
        .clock, .resetn, .frame_start,
        .move_done, .tiles_done, .player_done, .scan_done,
        .move_map_addr, .tile_map_addr,
        .stage, .move_go, .tiles_go, .player_go, .scan_go,
        .frame_busy, .map_addr
    );

    player_unit player_unit_inst (
        .clock, .resetn, .direction, .move_go, .player_go, .map_wall,
        .move_done, .player_done, .move_map_addr, .player_x, .player_y,
        .wr_en(player_wr_en), .wr_addr(player_wr_addr), .wr_color(player_wr_color)
    );

    tile_renderer tile_renderer_inst (
        .clock, .resetn, .tiles_go, .map_wall, .map_food,
        .tiles_done, .tile_map_addr,
        .wr_en(tile_wr_en), .wr_addr(tile_wr_addr), .wr_color(tile_wr_color)
    );

    frame_buffer frame_buffer_inst (
        .clock, .stage,
        .tile_wr_en, .tile_wr_addr, .tile_wr_color,
        .player_wr_en, .player_wr_addr, .player_wr_color,
        .rd_addr, .rd_color
    );

    pixel_streamer #(.PIXEL_CREDITS(PIXEL_CREDITS)) pixel_streamer_inst (
        .clock, .resetn, .scan_go, .pixel_credit, .rd_color,
        .scan_done, .rd_addr, .pixel_valid, .pixel_color
    );

endmodule

/* hdl/pixel_streamer.sv */
module pixel_streamer #(
    parameter int PIXEL_CREDITS = 4
) (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          scan_go,
    input  logic                          pixel_credit,
    input  video_pkg::color_t             rd_color,
    output logic                          scan_done,
    output logic [video_pkg::FB_AW-1:0]   rd_addr,
    output logic                          pixel_valid,
    output video_pkg::color_t             pixel_color
);

    localparam int CW        = $clog2(PIXEL_CREDITS + 1);
    localparam int LAST_ADDR = video_pkg::CANVAS_W * video_pkg::CANVAS_H - 1;

    logic [CW-1:0]  credits;    // Pixels the sink can still take
    logic           active;
    logic           issue;
    logic           last_rd;

    assign issue   = active && (credits != '0);
    assign last_rd = (rd_addr == video_pkg::FB_AW'(LAST_ADDR));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            credits     <= CW'(PIXEL_CREDITS);
            active      <= 1'b0;
            rd_addr     <= '0;
            pixel_valid <= 1'b0;
            scan_done   <= 1'b0;
        end else begin
            credits     <= credits - CW'(issue) + CW'(pixel_credit);  // Spend on read, refill on return
            pixel_valid <= issue;               // Frame buffer answers a cycle later
            scan_done   <= issue && last_rd;    // Same cycle as the last pixel
            if (scan_go)
                active <= 1'b1;
            else if (issue && last_rd)
                active <= 1'b0;
            if (issue)
                rd_addr <= last_rd ? '0 : rd_addr + 1'b1;
        end
    end

    assign pixel_color = rd_color;

endmodule

/* hdl/player_unit.sv */
module player_unit (
    input  logic                          clock,
    input  logic                          resetn,
    input  game_pkg::direction_t          direction,
    input  logic                          move_go,
    input  logic                          player_go,
    input  logic                          map_wall,
    output logic                          move_done,
    output logic                          player_done,
    output logic [game_pkg::MAP_AW-1:0]   move_map_addr,
    output logic [game_pkg::TILE_XW-1:0]  player_x,
    output logic [game_pkg::TILE_YW-1:0]  player_y,
    output logic                          wr_en,
    output logic [video_pkg::FB_AW-1:0]   wr_addr,
    output video_pkg::color_t             wr_color
);

    // Move check: read issued on go, wall bit back, then apply
    typedef enum logic [1:0] {MV_IDLE, MV_WALL, MV_APPLY} move_state_t;

    move_state_t                    move_state;
    logic [game_pkg::TILE_XW-1:0]   next_x, target_x;
    logic [game_pkg::TILE_YW-1:0]   next_y, target_y;
    logic                           legal, target_ok, wall_q;
    logic                           spr_busy;
    logic [2:0]                     sx, sy;     // Sprite pixel offsets

    // Target tile, left at the player when the move leaves the grid
    always_comb begin
        next_x = player_x;
        next_y = player_y;
        legal  = 1'b0;
        case (direction)
            game_pkg::UP:    if (player_y != '0) begin
                next_y = player_y - 1'b1;
                legal  = 1'b1;
            end
            game_pkg::LEFT:  if (player_x != '0) begin
                next_x = player_x - 1'b1;
                legal  = 1'b1;
            end
            game_pkg::DOWN:  if (int'(player_y) < game_pkg::GRID_H - 1) begin
                next_y = player_y + 1'b1;
                legal  = 1'b1;
            end
            game_pkg::RIGHT: if (int'(player_x) < game_pkg::GRID_W - 1) begin
                next_x = player_x + 1'b1;
                legal  = 1'b1;
            end
            default: ;  // NONE stays put
        endcase
    end

    assign move_map_addr = game_pkg::MAP_AW'(int'(next_y) * game_pkg::GRID_W + int'(next_x));
    assign move_done     = (move_state == MV_APPLY);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            move_state <= MV_IDLE;
            player_x   <= game_pkg::TILE_XW'(game_pkg::PLAYER_START_X);
            player_y   <= game_pkg::TILE_YW'(game_pkg::PLAYER_START_Y);
        end else begin
            case (move_state)
                MV_IDLE:  if (move_go) move_state <= MV_WALL;
                MV_WALL:  move_state <= MV_APPLY;
                MV_APPLY: begin
                    move_state <= MV_IDLE;
                    if (target_ok && !wall_q) begin   // Open tile inside the grid
                        player_x <= target_x;
                        player_y <= target_y;
                    end
                end
                default:  move_state <= MV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (move_go) begin
            target_x  <= next_x;
            target_y  <= next_y;
            target_ok <= legal;
        end
        if (move_state == MV_WALL)
            wall_q <= map_wall;     // Map answer for the target tile
    end

    // Sprite pass, 25 slots with the write one cycle behind
    always_ff @(posedge clock) begin
        if (!resetn) begin
            spr_busy    <= 1'b0;
            sx          <= '0;
            sy          <= '0;
            wr_en       <= 1'b0;
            player_done <= 1'b0;
        end else begin
            wr_en       <= spr_busy && video_pkg::PLAYER_SPRITE[int'(sy) * 5 + int'(sx)];
            player_done <= spr_busy && (int'(sx) == game_pkg::TILE_PX - 1)
                           && (int'(sy) == game_pkg::TILE_PX - 1);
            if (player_go) begin
                spr_busy <= 1'b1;
            end else if (spr_busy) begin
                if (int'(sx) == game_pkg::TILE_PX - 1) begin
                    sx <= '0;
                    if (int'(sy) == game_pkg::TILE_PX - 1) begin
                        sy       <= '0;
                        spr_busy <= 1'b0;
                    end else begin
                        sy <= sy + 3'd1;
                    end
                end else begin
                    sx <= sx + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        wr_addr <= video_pkg::FB_AW'((int'(player_y) * game_pkg::TILE_PX + int'(sy))
                   * video_pkg::CANVAS_W + int'(player_x) * game_pkg::TILE_PX + int'(sx));
    end

    assign wr_color = video_pkg::PLAYER_COLOR;  // Masked pixels are simply not written

endmodule

/* hdl/tile_renderer.sv */
module tile_renderer (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          tiles_go,
    input  logic                          map_wall,
    input  logic                          map_food,
    output logic                          tiles_done,
    output logic [game_pkg::MAP_AW-1:0]   tile_map_addr,
    output logic                          wr_en,
    output logic [video_pkg::FB_AW-1:0]   wr_addr,
    output video_pkg::color_t             wr_color
);

    logic                           busy;
    logic [2:0]                     dx, dy;     // Offsets inside the tile
    logic [game_pkg::TILE_XW-1:0]   tx;         // Tile column
    logic [game_pkg::TILE_YW-1:0]   ty;         // Tile row
    logic [video_pkg::FB_AW-1:0]    pix_addr;   // Raster pixel address
    logic                           last_pixel;
    logic                           centre_q;

    // Raster walk: dx fastest, then tile column, then dy, then tile row
    assign last_pixel = (int'(dx) == game_pkg::TILE_PX - 1) && (int'(tx) == game_pkg::GRID_W - 1)
                     && (int'(dy) == game_pkg::TILE_PX - 1) && (int'(ty) == game_pkg::GRID_H - 1);

    assign tile_map_addr = game_pkg::MAP_AW'(int'(ty) * game_pkg::GRID_W + int'(tx));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy       <= 1'b0;
            dx         <= '0;
            dy         <= '0;
            tx         <= '0;
            ty         <= '0;
            pix_addr   <= '0;
            wr_en      <= 1'b0;
            tiles_done <= 1'b0;
        end else begin
            wr_en      <= busy;                 // Write trails the map read by a cycle
            tiles_done <= busy && last_pixel;   // Together with the last write
            if (tiles_go) begin
                busy <= 1'b1;
            end else if (busy) begin
                pix_addr <= last_pixel ? '0 : pix_addr + 1'b1;
                if (int'(dx) == game_pkg::TILE_PX - 1) begin
                    dx <= '0;
                    if (int'(tx) == game_pkg::GRID_W - 1) begin
                        tx <= '0;
                        if (int'(dy) == game_pkg::TILE_PX - 1) begin
                            dy <= '0;
                            if (int'(ty) == game_pkg::GRID_H - 1) begin
                                ty   <= '0;
                                busy <= 1'b0;  // Whole canvas covered
                            end else begin
                                ty <= ty + 1'b1;
                            end
                        end else begin
                            dy <= dy + 3'd1;
                        end
                    end else begin
                        tx <= tx + 1'b1;
                    end
                end else begin
                    dx <= dx + 3'd1;
                end
            end
        end
    end

    // Address and dot position wait one cycle for the map data
    always_ff @(posedge clock) begin
        wr_addr  <= pix_addr;
        centre_q <= (int'(dx) == game_pkg::TILE_PX / 2) && (int'(dy) == game_pkg::TILE_PX / 2);
    end

    always_comb begin
        if (map_wall)
            wr_color = video_pkg::WALL_COLOR;
        else if (map_food && centre_q)
            wr_color = video_pkg::FOOD_COLOR;   // Dot at tile centre
        else
            wr_color = video_pkg::BACK_COLOR;
    end

endmodule

/* hdl/video_pkg.sv */
package video_pkg;

    // Canvas is 29x13 tiles of 5x5 pixels
    localparam int CANVAS_W = 145;
    localparam int CANVAS_H = 65;
    localparam int FB_AW    = 14;   // Pixel address is row * CANVAS_W + column

    typedef logic [11:0] color_t;   // 4 bits each of R, G, B

    // Palette
    localparam color_t WALL_COLOR   = 12'h00f;
    localparam color_t FOOD_COLOR   = 12'hfff;
    localparam color_t BACK_COLOR   = 12'h000;
    localparam color_t PLAYER_COLOR = 12'hff0;

    // Player sprite, bit dy*5+dx set where the sprite covers the tile
    // LSB is the top left pixel
    //   row 0  .###.
    //   row 1  ####.
    //   row 2  ###..   mouth faces right
    //   row 3  ####.
    //   row 4  .###.
    localparam logic [24:0] PLAYER_SPRITE = 25'b01110_01111_00111_01111_01110;

endpackage

/* maze_display.f */
hdl/game_pkg.sv
hdl/video_pkg.sv
hdl/frame_sequencer.sv
hdl/tile_renderer.sv
hdl/player_unit.sv
hdl/frame_buffer.sv
hdl/pixel_streamer.sv
hdl/maze_display.sv
tests/maze_display_chk.sv
tests/maze_display_checker.sv
tests/maze_display_tb.sv

/* tests/maze_display_checker.sv */
module maze_display_checker #(
    parameter int MAP_WORDS = game_pkg::GRID_W * game_pkg::GRID_H
) (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          frame_busy,
    input  logic                          pixel_valid,
    input  video_pkg::color_t             pixel_color,
    input  logic [game_pkg::TILE_XW-1:0]  player_x,
    input  logic [game_pkg::TILE_YW-1:0]  player_y,
    input  logic [MAP_WORDS-1:0]          wall_bits,
    input  logic [MAP_WORDS-1:0]          food_bits,
    input  int                            expected_x,
    input  int                            expected_y,
    output int                            frame_count,
    output int                            check_count,
    output int                            error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PIXELS = video_pkg::CANVAS_W * video_pkg::CANVAS_H;
    localparam int SHOWN  = 8;  // Pixel error lines per frame

    logic               busy_q;
    int                 pixel_index, frame_errors;
    video_pkg::color_t  want;

    // Canvas pixel from map and player tile
    function automatic video_pkg::color_t expected_color(int index, int px, int py);
        int col, row, tx, ty, dx, dy, tile;
        col  = index % video_pkg::CANVAS_W;
        row  = index / video_pkg::CANVAS_W;
        tx   = col / game_pkg::TILE_PX;
        ty   = row / game_pkg::TILE_PX;
        dx   = col % game_pkg::TILE_PX;
        dy   = row % game_pkg::TILE_PX;
        tile = ty * game_pkg::GRID_W + tx;
        if (tx == px && ty == py && video_pkg::PLAYER_SPRITE[dy * game_pkg::TILE_PX + dx])
            return video_pkg::PLAYER_COLOR;     // Sprite on top
        if (wall_bits[tile])
            return video_pkg::WALL_COLOR;
        if (food_bits[tile] && dx == 2 && dy == 2)
            return video_pkg::FOOD_COLOR;       // Centre dot
        return video_pkg::BACK_COLOR;
    endfunction

    always @(posedge clock) begin
        if (!resetn) begin
            busy_q       = 1'b0;
            pixel_index  = 0;
            frame_errors = 0;
            frame_count  = 0;
            check_count  = 0;
            error_count  = 0;
        end else begin
            if (pixel_valid) begin
                want = expected_color(pixel_index, expected_x, expected_y);
                check_count++;
                if (pixel_index >= PIXELS || pixel_color !== want) begin
                    frame_errors++;
                    if (frame_errors <= SHOWN)
                        $display("** Error @%0t: frame %0d pixel %0d (x %0d, y %0d) is %h, expected %h",
                                 $time, frame_count, pixel_index, pixel_index % video_pkg::CANVAS_W,
                                 pixel_index / video_pkg::CANVAS_W, pixel_color, want);
                end
                pixel_index++;  // Raster order
            end
            if (busy_q && !frame_busy) begin   // Frame just ended
                if (pixel_index != PIXELS) begin
                    frame_errors++;
                    $display("** Error @%0t: frame %0d sent %0d pixels, expected %0d",
                             $time, frame_count, pixel_index, PIXELS);
                end
                if (int'(player_x) != expected_x || int'(player_y) != expected_y) begin
                    frame_errors++;
                    $display("** Error @%0t: frame %0d player at (%0d,%0d), expected (%0d,%0d)",
                             $time, frame_count, player_x, player_y, expected_x, expected_y);
                end
                $display("Frame %0d: player (%0d,%0d), %0d pixels, %0d errors",
                         frame_count, player_x, player_y, pixel_index, frame_errors);
                error_count += frame_errors;
                frame_errors = 0;
                pixel_index  = 0;
                frame_count++;
            end
            busy_q = frame_busy;
        end
    end

endmodule

/* tests/maze_display_chk.sv */
module maze_display_chk #(
    parameter int PIXEL_CREDITS = 4
) (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          frame_busy,
    input  logic                          pixel_valid,
    input  logic                          pixel_credit,
    input  logic [game_pkg::TILE_XW-1:0]  player_x,
    input  logic [game_pkg::TILE_YW-1:0]  player_y
);
    timeunit 1ns;
    timeprecision 1ps;

    int   failures = 0;
    int   in_flight;    // Pixels sent against credits the streamer has counted
    logic credit_q;     // A returned credit reaches the counter a cycle later

    always @(posedge clock) begin
        if (!resetn) begin
            in_flight <= 0;
            credit_q  <= 1'b0;
        end else begin
            credit_q  <= pixel_credit;
            in_flight <= in_flight + int'(pixel_valid) - int'(credit_q);
        end
    end

    valid_in_frame: assert property (@(posedge clock) disable iff (!resetn)
        pixel_valid |-> frame_busy)
        else begin
            $error("pixel_valid high outside a frame");
            failures++;
        end

    // Read spent its credit a cycle before its pixel_valid
    credit_bound: assert property (@(posedge clock) disable iff (!resetn)
        in_flight + int'(pixel_valid) <= PIXEL_CREDITS)
        else begin
            $error("%0d pixels issued with %0d credits",
                   in_flight + int'(pixel_valid), PIXEL_CREDITS);
            failures++;
        end

    idle_after_reset: assert property (@(posedge clock) !resetn |=> !frame_busy)
        else begin
            $error("frame_busy high right after reset");
            failures++;
        end

    player_in_grid: assert property (@(posedge clock) disable iff (!resetn)
        (int'(player_x) < game_pkg::GRID_W) && (int'(player_y) < game_pkg::GRID_H))
        else begin
            $error("Player tile (%0d,%0d) off the grid", player_x, player_y);
            failures++;
        end

endmodule

bind maze_display maze_display_chk #(.PIXEL_CREDITS(PIXEL_CREDITS)) maze_display_chk_inst (
    .clock(clock),
    .resetn(resetn),
    .frame_busy(frame_busy),
    .pixel_valid(pixel_valid),
    .pixel_credit(pixel_credit),
    .player_x(player_x),
    .player_y(player_y)
);

/* tests/maze_display_input.txt */
// First 13 rows hold the maze (# wall, . food, space empty)
// Then one frame per line with direction N U L D R and expected player x y
 ############################
  ..........#...............#
#..#.....  .#.....#.....  ..#
##.#.###.#####.#####.###.#..#
#.....#.....#.....#.....#...#
#.###.#.###   ###.#.###.#.#.#
......#.....   .....#........
#.#.#.###.#.###   ###.#.###.#
#...#.....#.....#.....#.....#
#.#.###.#####.#####.###.#.#.#
#..  .....#.....#.....  ....#
#.............#.............#
#############################
N 1 1
R 2 1
D 2 2
L 1 2
D 1 2
U 1 1
U 1 1
L 0 1
L 0 1
U 0 0
U 0 0
R 0 0
D 0 1

/* tests/maze_display_tb.sv */
module tb_clock (
    output logic clock
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clock = 1'b0;
    always #5 clock = ~clock;   // 10 ns period
endmodule

module maze_display_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CREDITS      = 4;
    localparam int MAP_WORDS    = game_pkg::GRID_W * game_pkg::GRID_H;
    localparam int FRAME_CYCLES = video_pkg::CANVAS_W * video_pkg::CANVAS_H * 5 + 100;
    localparam string INPUT_FILE = "tests/maze_display_input.txt";

    logic                           clock, resetn, frame_start;
    game_pkg::direction_t           direction;
    logic                           map_wall, map_food, pixel_credit;
    logic                           frame_busy, pixel_valid;
    logic [game_pkg::MAP_AW-1:0]    map_addr, held_addr;
    logic [game_pkg::TILE_XW-1:0]   player_x;
    logic [game_pkg::TILE_YW-1:0]   player_y;
    video_pkg::color_t              pixel_color;

    logic [MAP_WORDS-1:0]   wall_bits, food_bits;   // Maze from the input file
    game_pkg::direction_t   frame_dir [$];
    int                     frame_x [$], frame_y [$];
    int                     n_frames, expected_x, expected_y;
    int                     frame_count, check_count, error_count, stim_errors;
    int                     seed, delay, due_cycle, last_due, sink_cycle, cycles;
    int                     credit_due [$];     // Cycles at which credits go back
    bit                     loaded;

    tb_clock tb_clock_inst (.clock);

    maze_display #(.PIXEL_CREDITS(CREDITS)) maze_display_inst (
        .clock, .resetn, .frame_start, .direction, .map_wall, .map_food, .pixel_credit,
        .frame_busy, .map_addr, .player_x, .player_y, .pixel_valid, .pixel_color
    );

    maze_display_checker maze_display_checker_inst (
        .clock, .resetn, .frame_busy, .pixel_valid, .pixel_color, .player_x, .player_y,
        .wall_bits, .food_bits, .expected_x, .expected_y,
        .frame_count, .check_count, .error_count
    );

    function automatic logic map_bit(logic [MAP_WORDS-1:0] bits, logic [game_pkg::MAP_AW-1:0] addr);
        if (addr < MAP_WORDS)
            return bits[addr];
        return 1'b0;    // Outside the map
    endfunction

    function automatic game_pkg::direction_t letter_to_direction(byte letter);
        case (letter)
            "U": return game_pkg::UP;
            "L": return game_pkg::LEFT;
            "D": return game_pkg::DOWN;
            "R": return game_pkg::RIGHT;
            default: return game_pkg::NONE;
        endcase
    endfunction

    // Map ROM model, address of one cycle answered in the next
    always @(negedge clock) begin
        map_wall  = map_bit(wall_bits, held_addr);
        map_food  = map_bit(food_bits, held_addr);
        held_addr = map_addr;
    end

    // Display sink, one credit back per pixel after 0 to 3 cycles
    always @(negedge clock) begin
        sink_cycle++;
        if (pixel_valid) begin
            delay     = $unsigned($random(seed)) % 4;
            due_cycle = (sink_cycle + delay > last_due) ? sink_cycle + delay : last_due + 1;
            last_due  = due_cycle;  // One credit pulse per cycle
            credit_due.push_back(due_cycle);
        end
        pixel_credit = 1'b0;
        if (credit_due.size() > 0 && credit_due[0] <= sink_cycle) begin
            void'(credit_due.pop_front());
            pixel_credit = 1'b1;
        end
    end

    task automatic load_input(output bit ok);
        int    fd, code, row, x, y;
        string line;
        byte   c;
        ok  = 1'b0;
        row = 0;
        fd  = $fopen(INPUT_FILE, "r");
        if (fd == 0)
            return;
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.substr(0, 1) == "//")
                continue;   // Blank or comment
            if (row < game_pkg::GRID_H) begin
                for (x = 0; x < game_pkg::GRID_W; x++) begin
                    c = (x < line.len()) ? line.getc(x) : " ";
                    wall_bits[row * game_pkg::GRID_W + x] = (c == "#");
                    food_bits[row * game_pkg::GRID_W + x] = (c == ".");
                end
                row++;
            end else if ($sscanf(line.substr(1, line.len() - 1), "%d %d", x, y) == 2) begin
                frame_dir.push_back(letter_to_direction(line.getc(0)));
                frame_x.push_back(x);
                frame_y.push_back(y);
            end
        end
        $fclose(fd);
        n_frames = frame_x.size();
        ok = (row == game_pkg::GRID_H) && (n_frames > 0);
    endtask

    // One frame, plus a stray start while busy that must be ignored
    task automatic run_frame(input int idx);
        @(negedge clock);
        while (frame_busy)
            @(negedge clock);
        expected_x  = frame_x[idx];
        expected_y  = frame_y[idx];
        direction   = frame_dir[idx];   // Held until the next frame
        frame_start = 1'b1;
        @(negedge clock);
        frame_start = 1'b0;
        repeat (3) @(negedge clock);
        frame_start = frame_busy;
        @(negedge clock);
        frame_start = 1'b0;
        while (frame_busy)
            @(negedge clock);
    endtask

    initial begin
        bit ok;
        int total;
        resetn       = 1'b0;
        frame_start  = 1'b0;
        direction    = game_pkg::NONE;
        map_wall     = 1'b0;
        map_food     = 1'b0;
        pixel_credit = 1'b0;
        seed         = 44340;
        last_due     = 0;
        sink_cycle   = 0;
        stim_errors  = 0;
        expected_x   = game_pkg::PLAYER_START_X;
        expected_y   = game_pkg::PLAYER_START_Y;
        load_input(ok);
        if (!ok) begin
            $display("Input file %s is missing or has no maze and frames", INPUT_FILE);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (4) @(posedge clock);   // Reset for 4 cycles
            @(negedge clock);
            resetn = 1'b1;
            for (int i = 0; i < n_frames; i++)
                run_frame(i);
            repeat (20) @(negedge clock);   // Room for a wrongly accepted start
            if (frame_count != n_frames || frame_busy) begin
                $display("** Error @%0t: %0d frames ran for %0d accepted starts",
                         $time, frame_count, n_frames);
                stim_errors++;
            end
            total = error_count + stim_errors + maze_display_inst.maze_display_chk_inst.failures;
            $display("Frames %0d of %0d, pixel checks %0d, errors %0d, assertion failures %0d",
                     frame_count, n_frames, check_count, error_count + stim_errors,
                     maze_display_inst.maze_display_chk_inst.failures);
            if (total == 0)
                $display("STATUS: PASS");
            else
                $display("STATUS: FAIL");
            $finish;
        end
    end

    // Cycle limit from the frame count
    initial begin
        cycles = 0;
        wait (loaded);
        while (cycles < n_frames * FRAME_CYCLES + 100) begin
            @(posedge clock);
            cycles++;
        end
        $display("Run timed out after %0d cycles with frames still unfinished", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
